// ==== all.f ====
pit_pkg.sv
pit_clk_divider.sv
pit_control_fsm.sv
pit_timer_unit.sv
pit_top.sv
pit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the PIT testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module pit_tb -o pit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/pit_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "No errors"; then
    exit 0
fi
exit 1

// ==== pit_tb.sv ====
module pit_tb import pit_pkg::*; ();

    // Clock is named reset and the active-high reset is named clk
    logic reset;
    logic clk;
    logic [1:0] addr;
    logic [7:0] data_in;
    logic wr;
    logic rd;
    logic [7:0] data_out;
    logic [NUM_CHANNELS-1:0] gate;
    logic [NUM_CHANNELS-1:0] out;

    integer seed;
    int byte_errors;
    int bit_errors;
    int other_errors;
    // Rising clock edges since reset release
    int cyc;

    // Channel model, kept from the host writes
    logic [1:0] m_mode [NUM_CHANNELS];
    int m_reload [NUM_CHANNELS];

    pit_top dut (
        .reset    (reset),
        .clk      (clk),
        .addr     (addr),
        .data_in  (data_in),
        .wr       (wr),
        .rd       (rd),
        .data_out (data_out),
        .gate     (gate),
        .out      (out)
    );

    always #50 reset = ~reset;

    // Same phase as the divider, which also starts counting at reset release
    always @(posedge reset or posedge clk) begin
        if (clk) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    task automatic next_cycle();
        @(negedge reset);
    endtask

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return lo + r % (hi - lo + 1);
    endfunction

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            byte_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h at cycle %0d", name, got, exp, cyc);
            bit_errors++;
        end
    endtask

    // Write strobe held 1 to 3 clocks, then one clock idle
    task automatic host_write(input logic [1:0] a, input logic [7:0] d);
        int hold;
        hold = rand_range(1, 3);
        addr = a;
        data_in = d;
        wr = 1'b1;
        repeat (hold) next_cycle();
        wr = 1'b0;
        next_cycle();
    endtask

    // Read byte is stable while rd stays high
    task automatic host_read(input logic [1:0] a, output logic [7:0] d);
        int hold;
        hold = rand_range(1, 3);
        addr = a;
        rd = 1'b1;
        repeat (hold) next_cycle();
        d = data_out;
        rd = 1'b0;
        // Idle long enough for the byte pointer to advance
        repeat (2) next_cycle();
    endtask

    function automatic int reload_of(input logic [1:0] rw, input logic [15:0] value);
        int r;
        case (rw)
            RW_LOW:  r = int'(value[7:0]);
            RW_HIGH: r = int'(value[15:8]) * 256;
            default: r = int'(value);
        endcase
        // Zero counts the full 16-bit range
        if (r == 0) begin
            r = 65536;
        end
        return r;
    endfunction

    task automatic program_channel(input logic [1:0] ch, input logic [1:0] mode,
                                   input logic [1:0] rw, input logic [15:0] value);
        pit_ctrl_word_u cw;
        cw = '0;
        cw.mode_view.sel = ch;
        cw.mode_view.rw = rw;
        cw.mode_view.mode = {1'b0, mode};
        host_write(PORT_CTRL, cw);
        case (rw)
            RW_LOW:  host_write(ch, value[7:0]);
            RW_HIGH: host_write(ch, value[15:8]);
            default: begin
                host_write(ch, value[7:0]);
                host_write(ch, value[15:8]);
            end
        endcase
        // Count picks up the new reload a clock after the last write ends
        next_cycle();
        m_mode[ch] = mode;
        m_reload[ch] = reload_of(rw, value);
    endtask

    // Latch command, then low and high byte with a random gap between them
    task automatic read_latched(input logic [1:0] ch, output logic [7:0] lo, output logic [7:0] hi);
        pit_ctrl_word_u cw;
        cw = '0;
        cw.latch_view.sel = ch;
        cw.latch_view.latch = RW_LATCH;
        host_write(PORT_CTRL, cw);
        host_read(ch, lo);
        repeat (rand_range(0, 40)) next_cycle();
        host_read(ch, hi);
    endtask

    task automatic wait_fall(input logic [1:0] ch, input int limit, output logic found);
        logic prev;
        int waited;
        found = 1'b0;
        waited = 0;
        prev = out[ch];
        while (!found && waited < limit) begin
            next_cycle();
            waited++;
            found = prev && !out[ch];
            prev = out[ch];
        end
        if (!found) begin
            $display("Timeout: out[%0d] did not fall within %0d clocks", ch, limit);
            other_errors++;
        end
    endtask

    // One whole period from a falling edge, sampled every clock
    task automatic check_period(input logic [1:0] ch);
        int n;
        int low_clk;
        int high_clk;
        logic found;
        string name;
        n = m_reload[ch];
        name = $sformatf("out[%0d]", ch);
        if (m_mode[ch] == MODE_SQUARE) begin
            low_clk = (n / 2 + 1) * PIT_DIVIDE;
            high_clk = (n - n / 2) * PIT_DIVIDE;
        end else begin
            low_clk = PIT_DIVIDE;
            high_clk = (n - 1) * PIT_DIVIDE;
        end
        wait_fall(ch, 2 * (low_clk + high_clk) + 16, found);
        if (found) begin
            repeat (low_clk - 1) begin
                next_cycle();
                check_bit(name, out[ch], 1'b0);
            end
            repeat (high_clk) begin
                next_cycle();
                check_bit(name, out[ch], 1'b1);
            end
            next_cycle();
            check_bit(name, out[ch], 1'b0);
        end
    endtask

    // Square wave channel: gate low for some ticks, then a restart from the gate edge
    task automatic gate_restart(input logic [1:0] ch, input int off_ticks);
        int n;
        int t_fall;
        int tick_phase;
        logic exp_level;
        string name;
        n = m_reload[ch];
        name = $sformatf("out[%0d]", ch);
        gate[ch] = 1'b0;
        repeat (off_ticks * PIT_DIVIDE + 1) begin
            next_cycle();
            check_bit(name, out[ch], 1'b1);
        end
        gate[ch] = 1'b1;
        // Count clock rises at mid period and reaches the count two clocks later
        tick_phase = (PIT_DIVIDE / 2 + 2) % PIT_DIVIDE;
        // Reload lands two clocks after the gate edge, first tick comes after it
        t_fall = cyc + 3;
        while (t_fall % PIT_DIVIDE != tick_phase) begin
            t_fall++;
        end
        t_fall = t_fall + (n - n / 2 - 1) * PIT_DIVIDE;
        while (cyc < t_fall) begin
            next_cycle();
            exp_level = (cyc < t_fall);
            check_bit(name, out[ch], exp_level);
        end
    endtask

    initial begin
        int n;
        int v;
        int pick;
        logic [7:0] lo;
        logic [7:0] hi;
        logic [1:0] mode;
        logic [1:0] rw;
        seed = 32'h2858;
        byte_errors = 0;
        bit_errors = 0;
        other_errors = 0;
        reset = 1'b0;
        clk = 1'b1;
        addr = 2'd0;
        data_in = 8'h00;
        wr = 1'b0;
        rd = 1'b0;
        gate = '1;
        repeat (5) next_cycle();
        clk = 1'b0;
        next_cycle();

        // After reset every out is high and data_out is clear
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            check_bit($sformatf("out[%0d]", i), out[2'(i)], 1'b1);
        end
        check_byte("data_out", data_out, 8'h00);

        // Square wave and rate generator on channel 0
        program_channel(2'd0, MODE_SQUARE, RW_LOW, 16'(rand_range(2, 40)));
        repeat (2) check_period(2'd0);
        program_channel(2'd0, MODE_RATE, RW_BOTH, 16'(rand_range(2, 40)));
        repeat (2) check_period(2'd0);

        // Gate low freezes the count at the reload, so the latch is exact
        gate[1] = 1'b0;
        next_cycle();
        n = rand_range(2, 4000);
        program_channel(2'd1, MODE_SQUARE, RW_BOTH, 16'(n));
        repeat (2) begin
            read_latched(2'd1, lo, hi);
            check_byte("data_out", lo, 8'(n));
            check_byte("data_out", hi, 8'(n >> 8));
        end

        // Running count, any latched value stays within the reload
        gate[1] = 1'b1;
        repeat (2) begin
            repeat (rand_range(4, 60)) next_cycle();
            read_latched(2'd1, lo, hi);
            v = int'({hi, lo});
            if (v > m_reload[1]) begin
                $display("Latched count %0d on channel 1 is above reload %0d", v, m_reload[1]);
                other_errors++;
            end
        end

        // Live single byte reads
        gate[1] = 1'b0;
        next_cycle();
        n = rand_range(2, 255);
        program_channel(2'd1, MODE_SQUARE, RW_LOW, 16'(n));
        host_read(2'd1, lo);
        check_byte("data_out", lo, 8'(n));
        n = rand_range(1, 255);
        program_channel(2'd1, MODE_SQUARE, RW_HIGH, 16'(n * 256));
        host_read(2'd1, hi);
        check_byte("data_out", hi, 8'(n));
        gate[1] = 1'b1;

        // Gate restart on channel 2
        program_channel(2'd2, MODE_SQUARE, RW_BOTH, 16'(rand_range(2, 30)));
        check_period(2'd2);
        gate_restart(2'd2, rand_range(2, 10));
        check_period(2'd2);

        // Random mix over all channels
        repeat (2) begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                mode = (rand_range(0, 1) == 0) ? MODE_RATE : MODE_SQUARE;
                pick = rand_range(0, 2);
                if (pick == 0) begin
                    rw = RW_LOW;
                    n = rand_range(2, 60);
                end else if (pick == 1) begin
                    rw = RW_BOTH;
                    n = rand_range(2, 300);
                end else begin
                    rw = RW_HIGH;
                    n = 256;
                end
                program_channel(2'(i), mode, rw, 16'(n));
            end
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                check_period(2'(i));
            end
        end

        $display("Byte errors %0d, bit errors %0d, other errors %0d",
                 byte_errors, bit_errors, other_errors);
        if (byte_errors + bit_errors + other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== pit_top.sv ====
module pit_top import pit_pkg::*; (
    input  logic                    reset,
    input  logic                    clk,
    input  logic [1:0]              addr,
    input  logic [7:0]              data_in,
    input  logic                    wr,
    input  logic                    rd,
    output logic [7:0]              data_out,
    input  logic [NUM_CHANNELS-1:0] gate,
    output logic [NUM_CHANNELS-1:0] out
);

    // Shared count clock
    logic pit_clk;

    // Per channel command strobes
    logic [NUM_CHANNELS-1:0] configure;
    logic [NUM_CHANNELS-1:0] load;
    logic [NUM_CHANNELS-1:0] latch_count;
    logic [NUM_CHANNELS-1:0] read_count;

    // Shared command busses
    logic [7:0] reload_in;
    logic [1:0] rw_in;
    logic [1:0] mode_in;

    // Read bytes back from each channel
    logic [NUM_CHANNELS-1:0][7:0] count_out;

    pit_clk_divider u_divider (
        .reset   (reset),
        .clk     (clk),
        .pit_clk (pit_clk)
    );

    pit_control_fsm u_control (
        .reset       (reset),
        .clk         (clk),
        .addr        (addr),
        .data_in     (data_in),
        .wr          (wr),
        .rd          (rd),
        .count_out   (count_out),
        .data_out    (data_out),
        .configure   (configure),
        .load        (load),
        .latch_count (latch_count),
        .read_count  (read_count),
        .reload_in   (reload_in),
        .rw_in       (rw_in),
        .mode_in     (mode_in)
    );

    // One timer unit per channel
    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
        pit_timer_unit u_timer (
            .reset       (reset),
            .clk         (clk),
            .pit_clk     (pit_clk),
            .reload_in   (reload_in),
            .load        (load[i]),
            .rw_in       (rw_in),
            .mode_in     (mode_in),
            .configure   (configure[i]),
            .latch_count (latch_count[i]),
            .read_count  (read_count[i]),
            .count_out   (count_out[i]),
            .gate        (gate[i]),
            .out         (out[i])
        );
    end

endmodule

// ==== pit_timer_unit.sv ====
module pit_timer_unit import pit_pkg::*; (
    input  logic       reset,
    input  logic       clk,
    input  logic       pit_clk,
    input  logic [7:0] reload_in,
    input  logic       load,
    input  logic [1:0] rw_in,
    input  logic [1:0] mode_in,
    input  logic       configure,
    input  logic       latch_count,
    input  logic       read_count,
    output logic [7:0] count_out,
    input  logic       gate,
    output logic       out
);

    // Synchronized copies for edge detection
    logic pit_clk_q;
    logic pit_clk_last;
    logic gate_q;
    logic gate_last;

    // Channel configuration
    logic [1:0] mode;
    logic [1:0] rw;
    logic       rw_both;

    // Reload value, bit 16 set for a count of 65536
    logic [16:0] reload;
    logic [16:0] count;
    logic [7:0]  reload_low;
    logic        low_pending;
    logic [15:0] load_value;
    logic        load_complete;
    logic        load_done;

    // Latched read data and its pending bytes
    logic [15:0] latched_count;
    logic [1:0]  latched;
    logic        read_low;

    logic        tick;
    logic        trigger;
    logic        restart;
    logic        count_en;
    logic [16:0] rate_next;
    logic [16:0] half;

    assign tick = pit_clk_q & ~pit_clk_last;
    assign trigger = gate_q & ~gate_last;
    // New reload or gate edge both start a fresh period
    assign restart = trigger | load_done;
    assign count_en = tick & gate_q;
    assign rw_both = (rw != RW_LOW) && (rw != RW_HIGH);

    // Rate mode counts N-1 down to 0 then wraps
    assign rate_next = ((count == 17'd0) ? reload : count) - 17'd1;
    // Square wave drops low at the midpoint
    assign half = {1'b0, reload[16:1]};

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            pit_clk_q <= 1'b0;
            pit_clk_last <= 1'b0;
            gate_q <= 1'b0;
            gate_last <= 1'b0;
        end else begin
            pit_clk_q <= pit_clk;
            pit_clk_last <= pit_clk_q;
            gate_q <= gate;
            gate_last <= gate_q;
        end
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            mode <= 2'd0;
            rw <= RW_BOTH;
        end else if (configure) begin
            mode <= mode_in;
            rw <= rw_in;
        end
    end

    // Byte assembly for the three access codes
    always_comb begin
        case (rw)
            RW_LOW:  load_value = {8'h00, reload_in};
            RW_HIGH: load_value = {reload_in, 8'h00};
            default: load_value = {reload_in, reload_low};
        endcase
    end

    // Two byte access completes on the high byte
    assign load_complete = load & (~rw_both | low_pending);

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            reload <= 17'd0;
            low_pending <= 1'b0;
            load_done <= 1'b0;
        end else begin
            load_done <= 1'b0;
            if (configure) begin
                reload <= 17'd0;
                low_pending <= 1'b0;
            end else if (load_complete) begin
                // Zero stands for the full 65536 range
                reload <= {load_value == 16'h0000, load_value};
                low_pending <= 1'b0;
                load_done <= 1'b1;
            end else if (load) begin
                low_pending <= 1'b1;
            end
        end
    end

    // Low byte parked until the high byte arrives
    always_ff @(posedge reset) begin
        if (load && rw_both && !low_pending) begin
            reload_low <= reload_in;
        end
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            latched <= 2'b00;
            read_low <= 1'b1;
        end else if (configure) begin
            latched <= 2'b00;
            read_low <= 1'b1;
        end else if (latch_count && latched == 2'b00) begin
            // Two bytes pending for the low then high access
            latched <= rw_both ? 2'b11 : 2'b01;
            read_low <= 1'b1;
        end else if (read_count) begin
            latched <= {1'b0, latched[1]};
            if (rw_both) begin
                read_low <= ~read_low;
            end
        end
    end

    // Repeated latch commands are ignored until read out
    always_ff @(posedge reset) begin
        if (latch_count && latched == 2'b00) begin
            latched_count <= (rw == RW_HIGH) ? {8'h00, count[15:8]} : count[15:0];
        end else if (read_count) begin
            latched_count <= {8'h00, latched_count[15:8]};
        end
    end

    always_comb begin
        if (latched[0]) begin
            count_out = latched_count[7:0];
        end else begin
            case (rw)
                RW_LOW:  count_out = count[7:0];
                RW_HIGH: count_out = count[15:8];
                default: count_out = read_low ? count[7:0] : count[15:8];
            endcase
        end
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            count <= 17'd0;
            out <= 1'b1;
        end else begin
            case (mode)
                MODE_SQUARE: begin
                    if (restart) begin
                        count <= reload;
                        out <= 1'b1;
                    end else if (count_en) begin
                        if (count == 17'd0) begin
                            count <= reload;
                            out <= 1'b1;
                        end else begin
                            count <= count - 17'd1;
                            if ((count - 17'd1) == half) begin
                                out <= 1'b0;
                            end
                        end
                    end
                end

                MODE_RATE: begin
                    if (restart) begin
                        count <= reload - 17'd1;
                        out <= 1'b1;
                    end else if (count_en) begin
                        count <= rate_next;
                        // Low for the one tick spent at count 1
                        out <= (rate_next != 17'd1);
                    end
                end

                default: begin
                    // Unsupported modes hold the count
                    out <= 1'b1;
                end
            endcase

            // Gate low forces out high on the next clock
            if (!gate) begin
                out <= 1'b1;
            end
        end
    end

endmodule

// ==== pit_control_fsm.sv ====
module pit_control_fsm import pit_pkg::*; (
    input  logic                          reset,
    input  logic                          clk,
    input  logic [1:0]                    addr,
    input  logic [7:0]                    data_in,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [NUM_CHANNELS-1:0][7:0]  count_out,
    output logic [7:0]                    data_out,
    output logic [NUM_CHANNELS-1:0]       configure,
    output logic [NUM_CHANNELS-1:0]       load,
    output logic [NUM_CHANNELS-1:0]       latch_count,
    output logic [NUM_CHANNELS-1:0]       read_count,
    output logic [7:0]                    reload_in,
    output logic [1:0]                    rw_in,
    output logic [1:0]                    mode_in
);

    logic [1:0] state;
    // Port captured at the start of a read
    logic [1:0] rd_port;
    pit_ctrl_word_u ctrl;

    // Host byte viewed as a control word
    assign ctrl = data_in;

    // One-hot channel strobe, select code 3 maps to no channel
    function automatic logic [NUM_CHANNELS-1:0] chan_sel(input logic [1:0] idx);
        logic [NUM_CHANNELS-1:0] sel;
        sel = '0;
        if (idx < 2'(NUM_CHANNELS)) begin
            sel[idx] = 1'b1;
        end
        return sel;
    endfunction

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state <= ST_IDLE;
            rd_port <= 2'd0;
            data_out <= 8'h00;
            configure <= '0;
            load <= '0;
            latch_count <= '0;
            read_count <= '0;
        end else begin
            // Every strobe lasts a single cycle
            configure <= '0;
            load <= '0;
            latch_count <= '0;
            read_count <= '0;

            case (state)
                ST_IDLE: begin
                    if (wr) begin
                        state <= ST_WRITE_HOLD;
                        if (addr == PORT_CTRL) begin
                            // Latch command carries access code zero
                            if (ctrl.latch_view.latch == RW_LATCH) begin
                                latch_count <= chan_sel(ctrl.latch_view.sel);
                            end else begin
                                configure <= chan_sel(ctrl.mode_view.sel);
                            end
                        end else begin
                            load <= chan_sel(addr);
                        end
                    end else if (rd) begin
                        state <= ST_READ_HOLD;
                        rd_port <= addr;
                        // Control port reads back as zero
                        if (addr == PORT_CTRL) begin
                            data_out <= 8'h00;
                        end else begin
                            data_out <= count_out[addr];
                        end
                    end
                end

                ST_WRITE_HOLD: begin
                    // One command per write strobe
                    if (!wr) begin
                        state <= ST_IDLE;
                    end
                end

                ST_READ_HOLD: begin
                    // data_out holds until the host drops rd
                    if (!rd) begin
                        state <= ST_READ_DONE;
                        read_count <= chan_sel(rd_port);
                    end
                end

                ST_READ_DONE: begin
                    // Gives the channel a cycle to advance its byte pointer
                    state <= ST_IDLE;
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Shared command busses, valid alongside the strobes
    always_ff @(posedge reset) begin
        if (state == ST_IDLE && wr) begin
            reload_in <= data_in;
            rw_in <= ctrl.mode_view.rw;
            // Modes 6 and 7 alias to 2 and 3
            mode_in <= ctrl.mode_view.mode[1:0];
        end
    end

endmodule

// ==== pit_clk_divider.sv ====
module pit_clk_divider import pit_pkg::*; (
    input  logic reset,
    input  logic clk,
    output logic pit_clk
);

    // Position inside one count clock period
    logic [DIV_W-1:0] div_cnt;
    logic [DIV_W-1:0] div_next;

    // Wrap after PIT_DIVIDE system clocks
    assign div_next = (div_cnt == DIV_LAST) ? '0 : div_cnt + 1'b1;

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            div_cnt <= '0;
            // Count clock starts low
            pit_clk <= 1'b0;
        end else begin
            div_cnt <= div_next;
            // Upper half of the period drives the count clock high
            pit_clk <= (div_next >= DIV_HALF);
        end
    end

endmodule

// ==== pit_pkg.sv ====
package pit_pkg;

    // Channel count and host port map
    localparam int NUM_CHANNELS = 3;
    localparam logic [1:0] PORT_CTRL = 2'd3;

    // System clocks per count clock period, must be even
    localparam int PIT_DIVIDE = 4;
    localparam int DIV_W = $clog2(PIT_DIVIDE);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(PIT_DIVIDE - 1);
    localparam logic [DIV_W-1:0] DIV_HALF = DIV_W'(PIT_DIVIDE / 2);

    // Supported counting modes
    localparam logic [1:0] MODE_RATE = 2'd2;
    localparam logic [1:0] MODE_SQUARE = 2'd3;

    // Access codes from the control word
    localparam logic [1:0] RW_LATCH = 2'd0;
    localparam logic [1:0] RW_LOW = 2'd1;
    localparam logic [1:0] RW_HIGH = 2'd2;
    localparam logic [1:0] RW_BOTH = 2'd3;

    // Host access FSM state codes
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_WRITE_HOLD = 2'd1;
    localparam logic [1:0] ST_READ_HOLD = 2'd2;
    localparam logic [1:0] ST_READ_DONE = 2'd3;

    // Control word, seen either as a mode command or as a counter latch
    typedef union packed {
        struct packed {
            logic [1:0] sel;
            logic [1:0] rw;
            logic [2:0] mode;
            logic bcd;
        } mode_view;
        struct packed {
            logic [1:0] sel;
            logic [1:0] latch;
            logic [3:0] unused;
        } latch_view;
    } pit_ctrl_word_u;

endpackage
